/* logic/lsu_params.svh */
// Width, depth and latency macros for the load/store unit.
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

//////////////////////////////////////////////////
// Data path.
//////////////////////////////////////////////////

// Register and memory word width.
`define LSU_XLEN 64

// Byte address width.
`define LSU_ADDR_W 32

//////////////////////////////////////////////////
// Data RAM.
//////////////////////////////////////////////////

// Depth in 64-bit words.
`define LSU_RAM_WORDS 256

// Cycles from strobe to finish, 1 to 8.
`define LSU_RAM_LATENCY 2

`endif

/* logic/lsu_pkg.sv */
// Load/store unit types: data and address widths, access selects, pipeline bundles.
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   xlen_t;
    typedef logic [`LSU_ADDR_W-1:0] addr_t;
    typedef logic [4:0]             regaddr_t;
    typedef logic [`LSU_XLEN/8-1:0] wmask_t;

    // Load/store width and extension.
    typedef enum logic [3:0] {
        SEL_LB, SEL_LH, SEL_LW, SEL_LBU, SEL_LHU, SEL_LWU, SEL_LD,
        SEL_SB, SEL_SH, SEL_SW, SEL_SD,
        SEL_NONE
    } ls_sel_e;

    typedef enum logic [1:0] {KIND_ALU, KIND_LOAD, KIND_STORE} mem_kind_e;

    // Execute to memory.
    typedef struct packed {
        mem_kind_e kind;
        logic      rd_ena;
        regaddr_t  rd_addr;
        xlen_t     rd_data;
        addr_t     ls_addr;
        ls_sel_e   ls_sel;
    } exmem_t;

    // Memory to writeback.
    typedef struct packed {
        logic     rd_ena;
        regaddr_t rd_addr;
        xlen_t    rd_data;
    } memwb_t;

    typedef struct packed {
        logic   re;
        logic   we;
        addr_t  addr;
        xlen_t  wdata;
        wmask_t wmask;
    } dmem_req_t;

endpackage

`default_nettype wire

/* logic/mem_stage.sv */
// Memory access stage: load extraction and extension, store lane placement, strobes, stall.
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire logic               reset_i,
    input  wire lsu_pkg::exmem_t    exmem_i,
    input  wire lsu_pkg::xlen_t     rdata_i,
    input  wire logic               finish_i,
    output lsu_pkg::dmem_req_t      req_o,
    output lsu_pkg::memwb_t         result_o,
    output logic                    stall_req_o
);

    logic            is_load;
    logic            is_store;
    logic [2:0]      byte_off;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [31:0]     ld_word;
    lsu_pkg::xlen_t  load_data;
    lsu_pkg::xlen_t  st_data;
    lsu_pkg::wmask_t st_mask;

    assign is_load  = (exmem_i.kind == lsu_pkg::KIND_LOAD);
    assign is_store = (exmem_i.kind == lsu_pkg::KIND_STORE);
    assign byte_off = exmem_i.ls_addr[2:0];

    //////////////////////////////////////////////////
    // Load path.
    //////////////////////////////////////////////////

    // Halfword and word use the upper offset bits only.
    assign ld_byte = rdata_i[{byte_off, 3'b000} +: 8];
    assign ld_half = rdata_i[{byte_off[2:1], 4'b0000} +: 16];
    assign ld_word = rdata_i[{byte_off[2], 5'b00000} +: 32];

    always_comb begin
        case (exmem_i.ls_sel)
            lsu_pkg::SEL_LB:  load_data = lsu_pkg::xlen_t'($signed(ld_byte));
            lsu_pkg::SEL_LH:  load_data = lsu_pkg::xlen_t'($signed(ld_half));
            lsu_pkg::SEL_LW:  load_data = lsu_pkg::xlen_t'($signed(ld_word));
            lsu_pkg::SEL_LBU: load_data = lsu_pkg::xlen_t'(ld_byte);
            lsu_pkg::SEL_LHU: load_data = lsu_pkg::xlen_t'(ld_half);
            lsu_pkg::SEL_LWU: load_data = lsu_pkg::xlen_t'(ld_word);
            lsu_pkg::SEL_LD:  load_data = rdata_i;
            default:          load_data = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Store path.
    //////////////////////////////////////////////////

    always_comb begin
        st_data = '0;
        st_mask = '0;
        case (exmem_i.ls_sel)
            lsu_pkg::SEL_SB: begin
                st_data = lsu_pkg::xlen_t'(exmem_i.rd_data[7:0]) << {byte_off, 3'b000};
                st_mask = 8'b0000_0001 << byte_off;
            end
            lsu_pkg::SEL_SH: begin
                st_data = lsu_pkg::xlen_t'(exmem_i.rd_data[15:0]) << {byte_off[2:1], 4'b0000};
                st_mask = 8'b0000_0011 << {byte_off[2:1], 1'b0};
            end
            lsu_pkg::SEL_SW: begin
                st_data = lsu_pkg::xlen_t'(exmem_i.rd_data[31:0]) << {byte_off[2], 5'b00000};
                st_mask = 8'b0000_1111 << {byte_off[2], 2'b00};
            end
            lsu_pkg::SEL_SD: begin
                st_data = exmem_i.rd_data;
                st_mask = '1;
            end
            default: begin
                st_data = '0;
                st_mask = '0;
            end
        endcase
        // Only a store may touch the lanes.
        if (!is_store) begin
            st_data = '0;
            st_mask = '0;
        end
    end

    //////////////////////////////////////////////////
    // Outputs.
    //////////////////////////////////////////////////

    assign req_o = '{
        re:    is_load,
        we:    is_store,
        addr:  exmem_i.ls_addr,
        wdata: st_data,
        wmask: st_mask
    };

    assign result_o = '{
        rd_ena:  exmem_i.rd_ena,
        rd_addr: exmem_i.rd_addr,
        rd_data: is_load ? load_data : exmem_i.rd_data
    };

    // Hold the pipe until the RAM finishes.
    assign stall_req_o = (is_load || is_store) && !finish_i;

    // A store the RAM completes must have hit at least one lane.
    a_store_mask: assert property (
        @(posedge finish_i) disable iff (reset_i)
        is_store |-> (st_mask != '0)
    ) else $error("mem_stage: store completed with an empty write mask");

endmodule

`default_nettype wire

/* logic/data_ram.sv */
// Byte-masked data RAM with a fixed-latency finish pulse.
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module data_ram (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire lsu_pkg::dmem_req_t  req_i,
    output lsu_pkg::xlen_t           rdata_o,
    output logic                     finish_o
);

    localparam int RAM_WORDS = `LSU_RAM_WORDS;
    localparam int IDX_W     = $clog2(RAM_WORDS);
    localparam int LATENCY   = `LSU_RAM_LATENCY;

    lsu_pkg::xlen_t   mem_q [RAM_WORDS];
    logic [IDX_W-1:0] ram_idx;
    logic             strobe;
    logic             busy;
    logic [3:0]       lat_cnt;
    logic [3:0]       elapsed;
    logic             start;
    logic             last;

    assign ram_idx = req_i.addr[IDX_W+2:3];
    assign strobe  = req_i.re || req_i.we;

    // No restart in the finish cycle, the bundle is still held.
    assign start   = strobe && !busy && !finish_o;
    assign elapsed = busy ? lat_cnt + 4'd1 : 4'd1;
    assign last    = (start || busy) && (elapsed == 4'(LATENCY));

    //////////////////////////////////////////////////
    // Latency counter.
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy     <= 1'b0;
            lat_cnt  <= '0;
            finish_o <= 1'b0;
        end else begin
            finish_o <= last;
            if (last) begin
                busy    <= 1'b0;
                lat_cnt <= '0;
            end else if (start || busy) begin
                busy    <= 1'b1;
                lat_cnt <= elapsed;
            end
        end
    end

    // Storage. Read and write both land on the finishing edge.
    always_ff @(posedge clk) begin
        if (last && req_i.re) begin
            rdata_o <= mem_q[ram_idx];
        end
        if (last && req_i.we) begin
            for (int b = 0; b < `LSU_XLEN / 8; b++) begin
                if (req_i.wmask[b]) begin
                    mem_q[ram_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    a_finish_has_strobe: assert property (
        @(posedge clk) disable iff (reset_i)
        $rose(finish_o) |-> $past(strobe)
    ) else $error("data_ram: finish without a strobe");

endmodule

`default_nettype wire

/* logic/mem_wb_reg.sv */
// Memory-to-writeback pipeline register with stall hold.
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic              stall_i,
    input  wire lsu_pkg::memwb_t   result_i,
    output lsu_pkg::memwb_t        wb_o
);

    //////////////////////////////////////////////////
    // Writeback register.
    //////////////////////////////////////////////////

    // Holds its value while the access is outstanding.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o <= '0;
        end else if (!stall_i) begin
            wb_o <= result_i;
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
// Load/store unit top: access stage, data RAM and writeback register.
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire lsu_pkg::exmem_t   exmem_i,
    output lsu_pkg::memwb_t        wb_o,
    output logic                   stall_o
);

    lsu_pkg::dmem_req_t dmem_req;
    lsu_pkg::xlen_t     ram_rdata;
    logic               ram_finish;
    lsu_pkg::memwb_t    mem_result;
    logic               stall_req;

    //////////////////////////////////////////////////
    // Memory stage and RAM.
    //////////////////////////////////////////////////

    mem_stage i_mem_stage (
        .reset_i     (reset_i),
        .exmem_i     (exmem_i),
        .rdata_i     (ram_rdata),
        .finish_i    (ram_finish),
        .req_o       (dmem_req),
        .result_o    (mem_result),
        .stall_req_o (stall_req)
    );

    data_ram i_data_ram (
        .clk      (clk),
        .reset_i  (reset_i),
        .req_i    (dmem_req),
        .rdata_o  (ram_rdata),
        .finish_o (ram_finish)
    );

    // Writeback.
    mem_wb_reg i_mem_wb_reg (
        .clk      (clk),
        .reset_i  (reset_i),
        .stall_i  (stall_req),
        .result_i (mem_result),
        .wb_o     (wb_o)
    );

    assign stall_o = stall_req;

endmodule

`default_nettype wire

/* verification/lsu_tb.sv */
// Load/store unit testbench: clock, reset, random stimulus, shadow memory, assertions.
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;

    localparam int LATENCY    = `LSU_RAM_LATENCY;
    localparam int TEST_WORDS = 16;
    localparam int SHADOW_AW  = $clog2(TEST_WORDS * 8);
    localparam int WAIT_LIMIT = 50;

    logic                clk;
    logic                reset_i;
    lsu_pkg::exmem_t     exmem;
    lsu_pkg::memwb_t     wb;
    logic                stall;

    integer              seed;
    logic [7:0]          shadow [TEST_WORDS * 8];
    lsu_pkg::ls_sel_e    load_sels [6];
    logic                started;
    logic                armed;
    logic                capt;
    lsu_pkg::memwb_t     exp_wb;
    lsu_pkg::memwb_t     exp_q;
    int                  stall_run;
    int                  idle_errors;
    int                  stall_errors;
    int                  wb_errors;
    int                  loads;
    int                  stores;
    int                  alu_ops;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    lsu_top i_dut (
        .clk     (clk),
        .reset_i (reset_i),
        .exmem_i (exmem),
        .wb_o    (wb),
        .stall_o (stall)
    );

    //////////////////////////////////////////////////
    // Monitor state and assertions.
    //////////////////////////////////////////////////

    // Capture edge flag, expected value at that edge, stall run length.
    always @(posedge clk) begin
        if (reset_i) begin
            capt      <= 1'b0;
            exp_q     <= '0;
            stall_run <= 0;
        end else begin
            capt      <= armed && !stall;
            exp_q     <= exp_wb;
            stall_run <= stall ? stall_run + 1 : 0;
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (reset_i)
        !started |-> (!stall && !wb.rd_ena)
    ) else begin
        idle_errors = idle_errors + 1;
        $display("CHECK FAILED at %0t: stall_o or rd_ena high before the first bundle", $time);
    end

    a_stall_length: assert property (@(posedge clk) disable iff (reset_i)
        $fell(stall) |-> (stall_run == LATENCY)
    ) else begin
        stall_errors = stall_errors + 1;
        $display("CHECK FAILED at %0t: stall lasted %0d cycles, expected %0d",
                 $time, stall_run, LATENCY);
    end

    a_stall_bound: assert property (@(posedge clk) disable iff (reset_i)
        stall |-> (stall_run < LATENCY)
    ) else begin
        stall_errors = stall_errors + 1;
        $display("CHECK FAILED at %0t: stall longer than %0d cycles", $time, LATENCY);
    end

    a_alu_no_stall: assert property (@(posedge clk) disable iff (reset_i)
        (exmem.kind == lsu_pkg::KIND_ALU) |-> !stall
    ) else begin
        stall_errors = stall_errors + 1;
        $display("CHECK FAILED at %0t: ALU op raised stall_o", $time);
    end

    a_wb_value: assert property (@(posedge clk) disable iff (reset_i)
        capt |-> (wb == exp_q)
    ) else begin
        wb_errors = wb_errors + 1;
        $display("CHECK FAILED at %0t: wb_o en %0b rd %0d data %h, expected en %0b rd %0d data %h",
                 $time, wb.rd_ena, wb.rd_addr, wb.rd_data,
                 exp_q.rd_ena, exp_q.rd_addr, exp_q.rd_data);
    end

    //////////////////////////////////////////////////
    // Reference model.
    //////////////////////////////////////////////////

    function automatic int pick_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic lsu_pkg::xlen_t random_xlen();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int access_bytes(lsu_pkg::ls_sel_e sel);
        case (sel)
            lsu_pkg::SEL_LB, lsu_pkg::SEL_LBU, lsu_pkg::SEL_SB: return 1;
            lsu_pkg::SEL_LH, lsu_pkg::SEL_LHU, lsu_pkg::SEL_SH: return 2;
            lsu_pkg::SEL_LW, lsu_pkg::SEL_LWU, lsu_pkg::SEL_SW: return 4;
            default: return 8;
        endcase
    endfunction

    // Little-endian gather from the shadow bytes, then extension.
    function automatic lsu_pkg::xlen_t expected_load(lsu_pkg::ls_sel_e sel, int addr);
        int             n;
        logic           msb;
        lsu_pkg::xlen_t value;
        n = access_bytes(sel);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i*8 +: 8] = shadow[SHADOW_AW'(addr + i)];
        end
        msb = value[n*8 - 1];
        if (sel == lsu_pkg::SEL_LB || sel == lsu_pkg::SEL_LH || sel == lsu_pkg::SEL_LW) begin
            for (int i = n; i < 8; i++) begin
                value[i*8 +: 8] = {8{msb}};
            end
        end
        return value;
    endfunction

    function automatic void update_shadow(lsu_pkg::ls_sel_e sel, int addr, lsu_pkg::xlen_t data);
        int n;
        n = access_bytes(sel);
        for (int i = 0; i < n; i++) begin
            shadow[SHADOW_AW'(addr + i)] = data[i*8 +: 8];
        end
    endfunction

    function automatic lsu_pkg::exmem_t make_bundle(lsu_pkg::mem_kind_e kind, logic rd_ena,
            lsu_pkg::regaddr_t rd_addr, lsu_pkg::xlen_t rd_data, int addr,
            lsu_pkg::ls_sel_e sel);
        lsu_pkg::exmem_t b;
        b.kind    = kind;
        b.rd_ena  = rd_ena;
        b.rd_addr = rd_addr;
        b.rd_data = rd_data;
        b.ls_addr = lsu_pkg::addr_t'(addr);
        b.ls_sel  = sel;
        return b;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus.
    //////////////////////////////////////////////////

    // Called on a falling edge; returns on the falling edge after writeback.
    task automatic issue(input lsu_pkg::exmem_t bundle, input logic check_wb,
            input lsu_pkg::memwb_t expected);
        int waited;
        exmem   = bundle;
        armed   = check_wb;
        exp_wb  = expected;
        started = 1'b1;
        if (bundle.kind == lsu_pkg::KIND_ALU) begin
            @(negedge clk);
        end else begin
            waited = 0;
            @(negedge clk);
            while (stall && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (stall) begin
                $display("Timeout: stall_o did not fall within %0d cycles at %0t",
                         WAIT_LIMIT, $time);
                $display("Test FAILED");
                $finish;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic store_and_shadow(lsu_pkg::ls_sel_e sel, int addr, lsu_pkg::xlen_t data);
        issue(make_bundle(lsu_pkg::KIND_STORE, 1'b0, '0, data, addr, sel), 1'b0, '0);
        update_shadow(sel, addr, data);
        stores++;
    endtask

    task automatic load_and_expect(lsu_pkg::ls_sel_e sel, int addr);
        lsu_pkg::regaddr_t rd;
        lsu_pkg::memwb_t   expected;
        rd = lsu_pkg::regaddr_t'(1 + pick_below(31));
        expected = '{rd_ena: 1'b1, rd_addr: rd, rd_data: expected_load(sel, addr)};
        issue(make_bundle(lsu_pkg::KIND_LOAD, 1'b1, rd, random_xlen(), addr, sel),
              1'b1, expected);
        loads++;
    endtask

    task automatic alu_passthrough(logic rd_ena);
        lsu_pkg::regaddr_t rd;
        lsu_pkg::xlen_t    data;
        lsu_pkg::memwb_t   expected;
        rd = lsu_pkg::regaddr_t'(pick_below(32));
        data = random_xlen();
        expected = '{rd_ena: rd_ena, rd_addr: rd, rd_data: data};
        issue(make_bundle(lsu_pkg::KIND_ALU, rd_ena, rd, data, pick_below(128),
              lsu_pkg::SEL_NONE), 1'b1, expected);
        alu_ops++;
    endtask

    initial begin
        int               word;
        int               off;
        int               size;
        lsu_pkg::ls_sel_e sel;
        seed         = 53284;
        started      = 1'b0;
        armed        = 1'b0;
        exp_wb       = '0;
        idle_errors  = 0;
        stall_errors = 0;
        wb_errors    = 0;
        loads        = 0;
        stores       = 0;
        alu_ops      = 0;
        load_sels    = '{lsu_pkg::SEL_LB, lsu_pkg::SEL_LH, lsu_pkg::SEL_LW,
                         lsu_pkg::SEL_LBU, lsu_pkg::SEL_LHU, lsu_pkg::SEL_LWU};
        exmem        = make_bundle(lsu_pkg::KIND_ALU, 1'b0, '0, '0, 0, lsu_pkg::SEL_NONE);
        reset_i      = 1'b1;
        repeat (16) @(negedge clk);
        reset_i = 1'b0;
        // Idle window after reset.
        repeat (4) @(negedge clk);

        // Fill every test word, read it back.
        for (int w = 0; w < TEST_WORDS; w++) begin
            store_and_shadow(lsu_pkg::SEL_SD, w * 8, random_xlen());
            load_and_expect(lsu_pkg::SEL_LD, w * 8);
        end

        // Partial stores, checked by a full doubleword read.
        for (int k = 0; k < 40; k++) begin
            word = pick_below(TEST_WORDS);
            case (pick_below(3))
                0:       sel = lsu_pkg::SEL_SB;
                1:       sel = lsu_pkg::SEL_SH;
                default: sel = lsu_pkg::SEL_SW;
            endcase
            size = access_bytes(sel);
            off = pick_below(8 / size) * size;
            store_and_shadow(sel, word * 8 + off, random_xlen());
            load_and_expect(lsu_pkg::SEL_LD, word * 8);
            if (k % 8 == 7) begin
                alu_passthrough(1'b1);
            end
        end

        // Narrow loads at every aligned offset, two words each.
        for (int s = 0; s < 6; s++) begin
            sel = load_sels[s];
            size = access_bytes(sel);
            for (int r = 0; r < 2; r++) begin
                word = pick_below(TEST_WORDS);
                for (off = 0; off < 8; off += size) begin
                    load_and_expect(sel, word * 8 + off);
                end
            end
        end

        repeat (8) alu_passthrough(1'b1);
        alu_passthrough(1'b0);
        repeat (3) @(negedge clk);

        $display("Errors: idle %0d, stall %0d, wb %0d; %0d loads, %0d stores, %0d ALU ops",
                 idle_errors, stall_errors, wb_errors, loads, stores, alu_ops);
        if (idle_errors + stall_errors + wb_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+logic
logic/lsu_pkg.sv
logic/mem_stage.sv
logic/data_ram.sv
logic/mem_wb_reg.sv
logic/lsu_top.sv
verification/lsu_tb.sv

/* Makefile */
# Verilator build and run of the load/store unit testbench.

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f compile.f --top-module lsu_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vlsu_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
